//--- verilog/nnTypes.sv
`default_nettype none

package nnTypes;

	// ####################
	// data path word
	// ####################

	// two's complement, all sums wrap at 32 bits
	typedef logic signed [31:0] dataWord;

	// ####################
	// vectors
	// ####################

	// word[i] holds feature i, sized to match nnWeights::featureCount
	typedef struct packed {
		dataWord [9:0] word;
	} featureVec;

	typedef struct packed {
		dataWord [3:0] word;   // one per hidden neuron
	} hiddenVec;

	typedef struct packed {
		dataWord [2:0] word;   // one per class
	} scoreVec;

	typedef struct packed {
		logic [1:0] classId;   // index of winning class
		dataWord score;        // its raw score
	} classResult;

	// ####################
	// controller
	// ####################

	typedef enum logic [1:0] {
		IDLE,   // waiting for req
		BUSY,   // vector in the pipeline
		DONE    // ack high, waiting for req to drop
	} ctrlState;

endpackage

`default_nettype wire

//--- verilog/nnWeights.sv
`default_nettype none

package nnWeights;

	// ####################
	// layer sizes
	// ####################

	localparam int featureCount = 10;
	localparam int hiddenCount = 4;
	localparam int classCount = 3;

	typedef enum logic {
		HIDDEN,   // relu after the sum
		OUTPUT    // raw class score
	} layerKind;

	// ####################
	// hidden layer
	// ####################

	// first column is positive on every row, so a negative feature 0 pulls all sums down
	localparam nnTypes::dataWord hiddenWeights [hiddenCount][featureCount] = '{
		'{ 4213, -178, 6266, -3195, -5259, -5279, 3589, 517, -2588, 3560 },
		'{ 2871, 4410, -1936, 722, 3318, -6120, -845, 2290, 5017, -1473 },
		'{ 5532, -3904, 1187, 6034, -2261, 909, -4478, 3762, -611, 2445 },
		'{ 1609, 2733, -5820, -1348, 4905, 3176, 2084, -3327, 1451, -4790 }
	};

	localparam nnTypes::dataWord hiddenBias [hiddenCount] = '{ -1302, 877, -2410, 356 };

	// ####################
	// output layer
	// ####################

	localparam nnTypes::dataWord outputWeights [classCount][hiddenCount] = '{
		'{ 37, -52, 18, 44 },
		'{ -21, 63, -9, 27 },
		'{ 55, 14, -38, -16 }
	};

	// classes 0 and 2 share a bias, they tie when every hidden output is zero
	localparam nnTypes::dataWord outputBias [classCount] = '{ 512, -730, 512 };

	// ####################
	// latencies
	// ####################

	localparam int nodeLatency = 3;     // input reg, mac, relu
	localparam int argMaxLatency = 1;

	function automatic int inputsOf(layerKind kind);
		if (kind == HIDDEN)
			return featureCount;
		return hiddenCount;
	endfunction

	function automatic int nodesOf(layerKind kind);
		if (kind == HIDDEN)
			return hiddenCount;
		return classCount;
	endfunction

	function automatic nnTypes::dataWord weightOf(layerKind kind, int node, int idx);
		if (kind == HIDDEN)
			return hiddenWeights[node][idx];
		return outputWeights[node][idx];
	endfunction

	function automatic nnTypes::dataWord biasOf(layerKind kind, int node);
		if (kind == HIDDEN)
			return hiddenBias[node];
		return outputBias[node];
	endfunction

endpackage

`default_nettype wire

//--- verilog/neuronNode.sv
`timescale 1ns/10ps
`default_nettype none

module neuronNode #(
	parameter nnWeights::layerKind kind = nnWeights::HIDDEN,
	parameter int nodeIndex = 0,
	localparam int inCount = nnWeights::inputsOf(kind)
)(
	input logic clk,
	input logic reset,
	input nnTypes::dataWord [inCount-1:0] inVec,
	output nnTypes::dataWord nodeOut
);

	localparam nnTypes::dataWord bias = nnWeights::biasOf(kind, nodeIndex);
	localparam bit useRelu = (kind == nnWeights::HIDDEN);

	nnTypes::dataWord [inCount-1:0] inReg;   // stage 1
	nnTypes::dataWord products [inCount];
	nnTypes::dataWord macSum;
	nnTypes::dataWord sumReg;                // stage 2

	// ####################
	// products
	// ####################

	for (genvar i = 0; i < inCount; i++)
	begin : g_mult
		localparam nnTypes::dataWord weight = nnWeights::weightOf(kind, nodeIndex, i);

		assign products[i] = inReg[i] * weight;   // low 32 bits only
	end

	always_comb
	begin
		macSum = bias;
		for (int i = 0; i < inCount; i++)
			macSum = macSum + products[i];
	end

	// ####################
	// pipeline
	// ####################

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inReg <= '0;
			sumReg <= '0;
			nodeOut <= '0;
		end
		else
		begin
			inReg <= inVec;
			sumReg <= macSum;
			if (useRelu && sumReg[31])
				nodeOut <= '0;   // relu clamps negatives
			else
				nodeOut <= sumReg;
		end
	end

endmodule

`default_nettype wire

//--- verilog/denseLayer.sv
`timescale 1ns/10ps
`default_nettype none

module denseLayer #(
	parameter nnWeights::layerKind kind = nnWeights::HIDDEN,
	localparam int inCount = nnWeights::inputsOf(kind),
	localparam int outCount = nnWeights::nodesOf(kind)
)(
	input logic clk,
	input logic reset,
	input logic inValid,
	input nnTypes::dataWord [inCount-1:0] inVec,
	output logic outValid,
	output nnTypes::dataWord [outCount-1:0] outVec
);

	localparam int depth = nnWeights::nodeLatency;

	logic [depth-1:0] validPipe;   // one bit per node stage

	// ####################
	// valid tracking
	// ####################

	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[depth-2:0], inValid};
	end

	assign outValid = validPipe[depth-1];   // lines up with nodeOut

	// ####################
	// neurons
	// ####################

	// every node sees the whole input vector
	for (genvar n = 0; n < outCount; n++)
	begin : g_node
		neuronNode #(
			.kind(kind),
			.nodeIndex(n)
		) u_neuronNode (
			.clk(clk),
			.reset(reset),
			.inVec(inVec),
			.nodeOut(outVec[n])
		);
	end

endmodule

`default_nettype wire

//--- verilog/argMaxUnit.sv
`timescale 1ns/10ps
`default_nettype none

module argMaxUnit (
	input logic clk,
	input logic reset,
	input logic inValid,
	input nnTypes::scoreVec scores,
	output logic outValid,
	output nnTypes::classResult best
);

	nnTypes::classResult pick;

	// ####################
	// selection
	// ####################

	// strict greater than, so an equal score never displaces a lower index
	always_comb
	begin
		pick.classId = '0;
		pick.score = scores.word[0];
		for (int c = 1; c < nnWeights::classCount; c++)
		begin
			if (scores.word[c] > pick.score)   // signed compare
			begin
				pick.classId = 2'(c);
				pick.score = scores.word[c];
			end
		end
	end

	// ####################
	// output register
	// ####################

	always_ff @(posedge clk)
	begin
		if (reset)
			outValid <= 1'b0;
		else
			outValid <= inValid;
	end

	always_ff @(posedge clk)
	begin
		if (inValid)
			best <= pick;
	end

endmodule

`default_nettype wire

//--- verilog/mlpClassifier.sv
`timescale 1ns/10ps
`default_nettype none

module mlpClassifier (
	input logic clk,
	input logic reset,
	input logic req,
	input nnTypes::featureVec features,
	output logic ack,
	output nnTypes::classResult result
);

	nnTypes::ctrlState state;
	nnTypes::featureVec captured;   // held for the hidden layer
	logic start;                    // one cycle per request
	logic takeReq;
	logic loadResult;

	nnTypes::hiddenVec hiddenOut;
	logic hiddenValid;
	nnTypes::scoreVec scoreOut;
	logic scoreValid;
	nnTypes::classResult bestOut;
	logic bestValid;

	assign takeReq = (state == nnTypes::IDLE) && req;
	assign loadResult = (state == nnTypes::BUSY) && bestValid;

	// ####################
	// controller
	// ####################

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= nnTypes::IDLE;
			start <= 1'b0;
			ack <= 1'b0;
		end
		else
		begin
			start <= takeReq;
			case (state)
				nnTypes::IDLE:
				begin
					if (req)
						state <= nnTypes::BUSY;
				end
				nnTypes::BUSY:
				begin
					if (bestValid)
					begin
						ack <= 1'b1;   // result is loaded on the same edge
						state <= nnTypes::DONE;
					end
				end
				nnTypes::DONE:
				begin
					if (!req)
					begin
						ack <= 1'b0;
						state <= nnTypes::IDLE;
					end
				end
				default:
				begin
					ack <= 1'b0;
					state <= nnTypes::IDLE;
				end
			endcase
		end
	end

	// ####################
	// data registers
	// ####################

	always_ff @(posedge clk)
	begin
		if (takeReq)
			captured <= features;
	end

	// stays put through DONE, so result holds while ack is high
	always_ff @(posedge clk)
	begin
		if (loadResult)
			result <= bestOut;
	end

	// ####################
	// data path
	// ####################

	denseLayer #(
		.kind(nnWeights::HIDDEN)
	) u_hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inValid(start),
		.inVec(captured.word),
		.outValid(hiddenValid),
		.outVec(hiddenOut.word)
	);

	denseLayer #(
		.kind(nnWeights::OUTPUT)
	) u_outputLayer (
		.clk(clk),
		.reset(reset),
		.inValid(hiddenValid),
		.inVec(hiddenOut.word),
		.outValid(scoreValid),
		.outVec(scoreOut.word)
	);

	argMaxUnit u_argMaxUnit (
		.clk(clk),
		.reset(reset),
		.inValid(scoreValid),
		.scores(scoreOut),
		.outValid(bestValid),
		.best(bestOut)
	);

endmodule

`default_nettype wire

//--- test/mlpClassifier_props.sv
`timescale 1ns/10ps
`default_nettype none

module mlpClassifierProps (
	input logic clk,
	input logic reset,
	input logic req,
	input logic ack,
	input nnTypes::classResult result,
	input nnTypes::ctrlState state
);

	// ####################
	// handshake
	// ####################

	ackLowInReset: assert property (@(posedge clk) reset |=> !ack && state == nnTypes::IDLE)
		else $error("ack or state not cleared by reset");

	ackRiseNeedsReq: assert property (@(posedge clk) disable iff (reset)
		$rose(ack) |-> $past(req))
		else $error("ack rose without req");

	resultHeld: assert property (@(posedge clk) disable iff (reset)
		ack |=> !ack || $stable(result))
		else $error("result changed while ack high");

	ackFollowsReq: assert property (@(posedge clk) disable iff (reset)
		$fell(req) |-> ##[0:2] !ack)
		else $error("ack did not fall after req dropped");

endmodule

bind mlpClassifier mlpClassifierProps u_mlpClassifierProps (
	.clk(clk),
	.reset(reset),
	.req(req),
	.ack(ack),
	.result(result),
	.state(state)
);

`default_nettype wire

//--- test/mlpClassifierTb.sv
`timescale 1ns/10ps
`default_nettype none

module mlpClassifierTb;

	localparam int tableSize = 6;
	localparam int tieRow = 4;
	localparam int randomCount = 20;
	localparam int waitLimit = 40;   // cycles per wait

	typedef struct packed {
		nnTypes::featureVec vec;
		nnTypes::classResult expected;
		int holdCycles;   // extra cycles req stays high after ack
	} testCase;

	logic clk;
	logic reset;
	logic req;
	nnTypes::featureVec features;
	logic ack;
	nnTypes::classResult result;

	testCase caseTable [tableSize];
	testCase randomCase;
	logic [31:0] rngState;

	mlpClassifier u_mlpClassifier (
		.clk(clk),
		.reset(reset),
		.req(req),
		.features(features),
		.ack(ack),
		.result(result)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ####################
	// reference model
	// ####################

	function automatic nnTypes::classResult referenceModel(nnTypes::featureVec f);
		nnTypes::dataWord hidden [nnWeights::hiddenCount];
		nnTypes::dataWord score [nnWeights::classCount];
		nnTypes::dataWord acc;
		nnTypes::dataWord bestScore;
		nnTypes::classResult best;
		for (int n = 0; n < nnWeights::hiddenCount; n++)
		begin
			acc = nnWeights::hiddenBias[n];
			for (int i = 0; i < nnWeights::featureCount; i++)
				acc = acc + f.word[i] * nnWeights::hiddenWeights[n][i];   // wraps at 32 bits
			hidden[n] = (acc < 0) ? '0 : acc;
		end
		for (int c = 0; c < nnWeights::classCount; c++)
		begin
			acc = nnWeights::outputBias[c];
			for (int n = 0; n < nnWeights::hiddenCount; n++)
				acc = acc + hidden[n] * nnWeights::outputWeights[c][n];
			score[c] = acc;   // no relu on the output layer
		end
		best.classId = 2'd0;
		bestScore = score[0];
		for (int c = 1; c < nnWeights::classCount; c++)
		begin
			if (score[c] > bestScore)   // ties keep the lower index
			begin
				best.classId = 2'(c);
				bestScore = score[c];
			end
		end
		best.score = bestScore;
		return best;
	endfunction

	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	function automatic nnTypes::featureVec tableVec(int row);
		nnTypes::featureVec v;
		v = '0;
		for (int i = 0; i < nnWeights::featureCount; i++)
		begin
			case (row)
				1: v.word[i] = i + 1;
				2: v.word[i] = (i % 2 == 1) ? -(i * 37) : i * 53 + 11;
				3: v.word[i] = 32'sh7ffe_0000 + i * 32'sd40503;   // products wrap
				4: v.word[i] = (i == 0) ? -32'sd1000 : 32'sd0;    // all hidden sums negative
				5: v.word[i] = 32'sh8000_0000;
				default: v.word[i] = 0;
			endcase
		end
		return v;
	endfunction

	// ####################
	// checks
	// ####################

	task automatic stopRun(string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkResult(nnTypes::classResult expected, nnTypes::classResult actual,
		string name);
		if (actual.classId !== expected.classId || actual.score !== expected.score)
			stopRun($sformatf("FAIL time=%0t %s expected classId=%0d score=%0d %s",
				$time, name, expected.classId, $signed(expected.score),
				$sformatf("actual classId=%0d score=%0d",
					actual.classId, $signed(actual.score))));
	endtask

	task automatic checkLevel(logic expected, logic actual, string name);
		if (actual !== expected)
			stopRun($sformatf("FAIL time=%0t %s expected=%b actual=%b",
				$time, name, expected, actual));
	endtask

	task automatic waitForAck(logic level, string what);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (ack !== level)
		begin
			if (cycles >= waitLimit)
				stopRun($sformatf("timeout: ack never went to %b during %s", level, what));
			else
			begin
				cycles++;
				@(negedge clk);
			end
		end
	endtask

	// one full four-phase handshake
	task automatic runRequest(testCase tc, string label);
		@(posedge clk);
		req <= 1'b1;
		features <= tc.vec;
		waitForAck(1'b1, label);
		checkResult(tc.expected, result, "result");
		for (int k = 0; k < tc.holdCycles; k++)
		begin
			@(negedge clk);
			checkLevel(1'b1, ack, "ack");
			checkResult(tc.expected, result, "result");
		end
		@(posedge clk);
		req <= 1'b0;
		waitForAck(1'b0, label);
	endtask

	// ####################
	// main sequence
	// ####################

	initial
	begin
		reset <= 1'b1;
		req <= 1'b0;
		features <= '0;
		rngState = 32'hd4f2;

		for (int r = 0; r < tableSize; r++)
		begin
			caseTable[r].vec = tableVec(r);
			caseTable[r].expected = referenceModel(caseTable[r].vec);
			caseTable[r].holdCycles = (r == 2) ? 10 : 0;   // back-pressure row
		end
		// equal biases and zero activations, class 0 must win
		caseTable[tieRow].expected.classId = 2'd0;
		caseTable[tieRow].expected.score = nnWeights::outputBias[0];

		repeat (5) @(posedge clk);
		reset <= 1'b0;

		repeat (5)
		begin
			@(negedge clk);
			checkLevel(1'b0, ack, "ack");
		end

		for (int r = 0; r < tableSize; r++)
			runRequest(caseTable[r], $sformatf("table row %0d", r));

		for (int r = 0; r < randomCount; r++)
		begin
			for (int i = 0; i < nnWeights::featureCount; i++)
				randomCase.vec.word[i] = nextRandom();
			randomCase.expected = referenceModel(randomCase.vec);
			randomCase.holdCycles = 0;
			runRequest(randomCase, $sformatf("random vector %0d", r));
		end

		@(negedge clk);
		checkLevel(1'b0, ack, "ack");
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
verilog/nnTypes.sv
verilog/nnWeights.sv
verilog/neuronNode.sv
verilog/denseLayer.sv
verilog/argMaxUnit.sv
verilog/mlpClassifier.sv
test/mlpClassifier_props.sv
test/mlpClassifierTb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the classifier testbench with Verilator and runs it.
# A failing check ends the run through $fatal, which gives a nonzero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
	--top-module mlpClassifierTb \
	-f build.f \
	-Mdir obj_dir

./obj_dir/VmlpClassifierTb
